// File: all.f
+incdir+tb
hw/lookup_data_pkg.sv
hw/lookup_ctrl_pkg.sv
hw/char_store.sv
hw/scan_counter.sv
hw/match_fsm.sv
hw/word_lookup.sv
tb/tb_word_lookup.sv

// File: Bender.yml
package:
  name: word_lookup

sources:
  - hw/lookup_data_pkg.sv
  - hw/lookup_ctrl_pkg.sv
  - hw/char_store.sv
  - hw/scan_counter.sv
  - hw/match_fsm.sv
  - hw/word_lookup.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_word_lookup.sv

// File: tb/lookup_model.svh
`ifndef LOOKUP_MODEL_SVH
`define LOOKUP_MODEL_SVH

char_t vocab_img [VOCAB_DEPTH];   // mirror of what the host wrote
char_t input_img [INPUT_DEPTH];

// length of the input word, last address ends it when no zero is stored
function automatic int input_word_len();
    int n;
    n = INPUT_DEPTH - 1;
    for (int k = INPUT_DEPTH - 1; k >= 0; k--) begin
        if (input_img[k] == 8'h00) begin
            n = k;
        end
    end
    return n;
endfunction

// first terminated word below len that equals the input word
function automatic lookup_res_t expected_result(input vocab_len_t len);
    lookup_res_t r;
    int          ilen;
    int          start;
    int          idx;
    bit          same;
    r     = '0;
    ilen  = input_word_len();
    start = 0;
    idx   = 0;
    if (ilen == 0) begin
        return r;   // empty input never found
    end
    for (int a = 0; a < int'(len); a++) begin
        if (vocab_img[a] == 8'h00) begin
            if (a - start == ilen) begin
                same = 1'b1;
                for (int k = 0; k < ilen; k++) begin
                    if (vocab_img[start + k] != input_img[k]) begin
                        same = 1'b0;
                    end
                end
                if (same) begin
                    r.found = 1'b1;
                    r.index = word_idx_t'(idx);
                    return r;
                end
            end
            idx++;   // empty words count too
            start = a + 1;
        end
    end
    return r;
endfunction

`endif

// File: tb/tb_word_lookup.sv
module tb_word_lookup import lookup_data_pkg::*, lookup_ctrl_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_DIRECTED  = 11;
    localparam int N_RANDOM    = 200;
    localparam int LATENCY_MAX = VOCAB_DEPTH + 3;
    localparam int CYCLE_LIMIT = (N_DIRECTED + N_RANDOM) * (VOCAB_DEPTH + INPUT_DEPTH + 80);

    logic        clk;
    logic        rst_n;
    vocab_wr_t   vocab_wr;
    input_wr_t   input_wr;
    logic        req;
    lookup_req_t req_data;
    logic        ack;
    lookup_res_t res;

    char_t vocab_next [VOCAB_DEPTH];   // staged contents for the next lookup
    char_t input_next [INPUT_DEPTH];
    int    pass_count;
    int    fail_count;
    int    cycle_count = 0;

    `include "lookup_model.svh"

    word_lookup dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .vocab_wr (vocab_wr),
        .input_wr (input_wr),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .res      (res)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    function automatic char_t rand_letter();
        return char_t'(8'h61 + $urandom_range(0, 3));   // a to d
    endfunction

    // '.' marks a terminator
    function automatic void stage_vocab(input string text);
        for (int a = 0; a < VOCAB_DEPTH; a++) begin
            if (a < text.len()) begin
                vocab_next[a] = (text[a] == ".") ? 8'h00 : char_t'(text[a]);
            end else begin
                vocab_next[a] = char_t'(8'h80 | a);
            end
        end
    endfunction

    function automatic void stage_input(input string text);
        for (int k = 0; k < INPUT_DEPTH; k++) begin
            if (k < text.len()) begin
                input_next[k] = char_t'(text[k]);
            end else if (k == text.len()) begin
                input_next[k] = 8'h00;
            end else begin
                input_next[k] = char_t'(8'hc0 | k);
            end
        end
    endfunction

    function automatic void record_test(input string name, input bit ok);
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("%-26s %s", name, ok ? "pass" : "fail");
    endfunction

    // both stores load in parallel, one address per cycle
    task automatic write_stores();
        for (int a = 0; a < VOCAB_DEPTH; a++) begin
            vocab_wr.en   = 1'b1;
            vocab_wr.addr = vocab_addr_t'(a);
            vocab_wr.ch   = vocab_next[a];
            vocab_img[a]  = vocab_next[a];
            input_wr.en   = 1'b0;
            if (a < INPUT_DEPTH) begin
                input_wr.en   = 1'b1;
                input_wr.addr = input_addr_t'(a);
                input_wr.ch   = input_next[a];
                input_img[a]  = input_next[a];
            end
            step();
        end
        vocab_wr = '0;
        input_wr = '0;
    endtask

    task automatic check_reset();
        bit ok;
        ok = 1'b1;
        if (ack !== 1'b0) begin
            $display("FAIL reset: ack expected %h got %h", 1'b0, ack);
            ok = 1'b0;
        end
        if (res !== '0) begin
            $display("FAIL reset: res expected %h got %h", 7'h00, res);
            ok = 1'b0;
        end
        repeat (4) begin
            step();
            if (ack !== 1'b0) begin
                $display("reset: ack rose while req was low");
                ok = 1'b0;
            end
        end
        record_test("reset and idle", ok);
    endtask

    task automatic run_lookup(input string name, input int len);
        lookup_res_t exp;
        lookup_res_t got;
        int          waited;
        int          hold;
        bit          ok;
        ok = 1'b1;
        write_stores();
        exp                = expected_result(vocab_len_t'(len));
        req_data.vocab_len = vocab_len_t'(len);
        req                = 1'b1;
        waited             = 0;
        do begin
            step();
            waited++;
        end while (!ack && waited < LATENCY_MAX);
        if (ack !== 1'b1) begin
            $display("%s: ack did not rise within %0d cycles of req", name, LATENCY_MAX);
            ok  = 1'b0;
            req = 1'b0;
            repeat (LATENCY_MAX + 2) begin
                step();   // let the engine drain back to idle
            end
        end else begin
            got = res;
            if (got.found !== exp.found) begin
                $display("FAIL %s: res.found expected %h got %h", name, exp.found, got.found);
                ok = 1'b0;
            end
            if (got.index !== exp.index) begin
                $display("FAIL %s: res.index expected %h got %h", name, exp.index, got.index);
                ok = 1'b0;
            end
            hold = $urandom_range(0, 5);
            repeat (hold) begin
                step();
                if (ack !== 1'b1) begin
                    $display("%s: ack dropped while req was still high", name);
                    ok = 1'b0;
                end
                if (res !== got) begin
                    $display("FAIL %s: res expected %h got %h", name, got, res);
                    ok = 1'b0;
                end
            end
            req = 1'b0;
            step();
            if (ack !== 1'b0) begin
                $display("%s: ack still high one cycle after req fell", name);
                ok = 1'b0;
            end
        end
        record_test(name, ok);
    endtask

    task automatic text_case(input string name, input string text, input string word,
                             input int len);
        stage_vocab(text);
        stage_input(word);
        run_lookup(name, len);
    endtask

    task automatic random_case(input int n);
        string text;
        string w;
        string word;
        string words[$];
        int    wlen;
        text = "";
        while (text.len() < VOCAB_DEPTH) begin
            w    = "";
            wlen = $urandom_range(0, 5);
            repeat (wlen) begin
                w = $sformatf("%s%c", w, rand_letter());
            end
            words.push_back(w);
            text = {text, w, "."};
        end
        if ($urandom_range(0, 1) == 1) begin
            word = words[$urandom_range(0, words.size() - 1)];
        end else begin
            word = "";
            wlen = $urandom_range(0, 4);
            repeat (wlen) begin
                word = $sformatf("%s%c", word, rand_letter());
            end
        end
        stage_vocab(text);
        stage_input(word);
        run_lookup($sformatf("random %0d", n), $urandom_range(0, VOCAB_DEPTH));
    endtask

    initial begin
        void'($urandom(32'h06f4c198));
        rst_n      = 1'b0;
        req        = 1'b0;
        req_data   = '0;
        vocab_wr   = '0;
        input_wr   = '0;
        pass_count = 0;
        fail_count = 0;
        repeat (5) begin
            step();
        end
        rst_n = 1'b1;

        check_reset();
        text_case("hit first word", "cat.dog.bird.fish.", "cat", 18);
        text_case("hit middle word", "cat.dog.bird.fish.", "dog", 18);
        text_case("hit last word", "cat.dog.bird.fish.", "fish", 18);
        text_case("miss", "cat.dog.bird.fish.", "cow", 18);
        text_case("input is prefix", "cat.dog.bird.fish.", "bir", 18);
        text_case("vocab word is prefix", "cat.dog.bird.fish.", "dogs", 18);
        text_case("empty words counted", "..cat..dog.", "dog", 11);
        text_case("last word cut off", "cat.dog.fish.", "fish", 11);
        text_case("empty input", ".cat.", "", 5);
        text_case("zero vocab length", "cat.", "cat", 0);
        text_case("input without terminator", "abcdabcdabcdabcd.abcdabcdabcdabc.",
                  "abcdabcdabcdabcd", 33);   // whole input store filled
        for (int n = 0; n < N_RANDOM; n++) begin
            random_case(n);
        end

        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: hw/word_lookup.sv
module word_lookup import lookup_data_pkg::*, lookup_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  vocab_wr_t   vocab_wr,
    input  input_wr_t   input_wr,
    input  logic        req,
    input  lookup_req_t req_data,
    output logic        ack,
    output lookup_res_t res
);

    vocab_addr_t vocab_addr;
    input_addr_t input_addr;
    char_t       vocab_ch;
    char_t       input_rd_ch;
    char_t       input_ch;
    word_idx_t   word_index;
    logic        at_end;
    cnt_cmd_t    cmd;

    char_store #(
        .DEPTH(VOCAB_DEPTH)
    ) vocab_store (
        .clk     (clk),
        .wr_en   (vocab_wr.en),
        .wr_addr (vocab_wr.addr),
        .wr_ch   (vocab_wr.ch),
        .rd_addr (vocab_addr),
        .rd_ch   (vocab_ch)
    );

    char_store #(
        .DEPTH(INPUT_DEPTH)
    ) input_store (
        .clk     (clk),
        .wr_en   (input_wr.en),
        .wr_addr (input_wr.addr),
        .wr_ch   (input_wr.ch),
        .rd_addr (input_addr),
        .rd_ch   (input_rd_ch)
    );

    assign input_ch = (input_addr == input_addr_t'(INPUT_DEPTH - 1)) ? '0 : input_rd_ch;  // last entry ends the word

    scan_counter scan_counter0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd        (cmd),
        .vocab_len  (req_data.vocab_len),   // host keeps it stable while req is high
        .vocab_addr (vocab_addr),
        .input_addr (input_addr),
        .word_index (word_index),
        .at_end     (at_end)
    );

    match_fsm match_fsm0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .ack        (ack),
        .vocab_ch   (vocab_ch),
        .input_ch   (input_ch),
        .at_end     (at_end),
        .cmd        (cmd),
        .word_index (word_index),
        .res        (res)
    );

endmodule

// File: hw/match_fsm.sv
module match_fsm import lookup_data_pkg::*, lookup_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req,
    output logic        ack,
    input  char_t       vocab_ch,
    input  char_t       input_ch,
    input  logic        at_end,
    output cnt_cmd_t    cmd,
    input  word_idx_t   word_index,
    output lookup_res_t res
);

    match_state_t state;
    match_state_t state_nxt;
    logic         word_start;       // nothing of the current word matched yet
    logic         word_start_nxt;
    logic         finish;
    logic         hit;
    logic         v_zero;
    logic         i_zero;
    logic         same;

    assign v_zero = (vocab_ch == '0);
    assign i_zero = (input_ch == '0);
    assign same   = (vocab_ch == input_ch);
    assign ack    = (state == DONE);

    always_comb begin
        state_nxt      = state;
        word_start_nxt = word_start;
        cmd            = '0;
        finish         = 1'b0;
        hit            = 1'b0;

        case (state)
            IDLE: begin
                cmd.clear      = 1'b1;
                word_start_nxt = 1'b1;
                if (req) begin
                    state_nxt = COMPARE;
                end
            end

            COMPARE: begin
                if (at_end) begin
                    finish = 1'b1;
                end else if (v_zero && i_zero && !word_start) begin
                    finish = 1'b1;   // both words end together
                    hit    = 1'b1;
                end else if (same && !v_zero) begin
                    cmd.inc_v      = 1'b1;
                    cmd.inc_i      = 1'b1;
                    word_start_nxt = 1'b0;
                end else if (v_zero) begin
                    // empty or too short vocab word, already on its terminator
                    cmd.inc_v      = 1'b1;
                    cmd.inc_word   = 1'b1;
                    cmd.restart_i  = 1'b1;
                    word_start_nxt = 1'b1;
                end else begin
                    cmd.inc_v = 1'b1;   // vocab char is nonzero so step past it now
                    state_nxt = SKIP;
                end
            end

            SKIP: begin
                if (at_end) begin
                    finish = 1'b1;   // unterminated last word
                end else begin
                    cmd.inc_v = 1'b1;
                    if (v_zero) begin
                        cmd.inc_word   = 1'b1;
                        cmd.restart_i  = 1'b1;
                        word_start_nxt = 1'b1;
                        state_nxt      = COMPARE;
                    end
                end
            end

            DONE: begin
                if (!req) begin
                    state_nxt = IDLE;
                end
            end

            default: begin
                state_nxt = IDLE;
            end
        endcase

        if (finish) begin
            state_nxt = DONE;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            word_start <= 1'b1;
        end else begin
            state      <= state_nxt;
            word_start <= word_start_nxt;
        end
    end

    // result is loaded once per lookup and held through DONE
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res <= '0;
        end else if (finish) begin
            res.found <= hit;
            res.index <= hit ? word_index : '0;
        end
    end

endmodule

// File: hw/scan_counter.sv
module scan_counter import lookup_data_pkg::*, lookup_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  cnt_cmd_t    cmd,
    input  vocab_len_t  vocab_len,
    output vocab_addr_t vocab_addr,
    output input_addr_t input_addr,
    output word_idx_t   word_index,
    output logic        at_end
);

    vocab_len_t v_pos;   // one bit wider than the address to reach full depth
    logic       i_last;

    assign vocab_addr = v_pos[$bits(vocab_addr_t)-1:0];
    assign at_end     = (v_pos == vocab_len);
    assign i_last     = (input_addr == input_addr_t'(INPUT_DEPTH - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v_pos <= '0;
        end else if (cmd.clear) begin
            v_pos <= '0;
        end else if (cmd.inc_v) begin
            v_pos <= v_pos + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            input_addr <= '0;
        end else if (cmd.clear || cmd.restart_i) begin
            input_addr <= '0;
        end else if (cmd.inc_i && !i_last) begin
            input_addr <= input_addr + 1'b1;   // sticks on last entry
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_index <= '0;
        end else if (cmd.clear) begin
            word_index <= '0;
        end else if (cmd.inc_word) begin
            word_index <= word_index + 1'b1;   // terminators passed so far
        end
    end

endmodule

// File: hw/char_store.sv
module char_store import lookup_data_pkg::*; #(
    parameter int DEPTH = INPUT_DEPTH
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  char_t                    wr_ch,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output char_t                    rd_ch
);

    char_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_ch;
        end
    end

    assign rd_ch = mem[rd_addr];   // async read, same cycle as address

endmodule

// File: hw/lookup_ctrl_pkg.sv
package lookup_ctrl_pkg;

    import lookup_data_pkg::*;

    typedef logic [$clog2(VOCAB_DEPTH)-1:0] word_idx_t;   // at most one word per address

    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        SKIP,
        DONE
    } match_state_t;

    // one cycle of counter control from the FSM
    typedef struct packed {
        logic clear;        // all counters to zero
        logic inc_v;
        logic inc_i;
        logic restart_i;    // back to first input char
        logic inc_word;
    } cnt_cmd_t;

    typedef struct packed {
        vocab_len_t vocab_len;   // addresses below this are searched
    } lookup_req_t;

    typedef struct packed {
        logic      found;
        word_idx_t index;        // zero on a miss
    } lookup_res_t;

endpackage

// File: hw/lookup_data_pkg.sv
package lookup_data_pkg;

    localparam int VOCAB_DEPTH = 64;
    localparam int INPUT_DEPTH = 16;

    typedef logic [7:0] char_t;                               // zero byte ends a word

    typedef logic [$clog2(VOCAB_DEPTH)-1:0] vocab_addr_t;
    typedef logic [$clog2(INPUT_DEPTH)-1:0] input_addr_t;
    typedef logic [$clog2(VOCAB_DEPTH+1)-1:0] vocab_len_t;    // 0 up to full depth

    // host write port into the vocabulary store
    typedef struct packed {
        logic        en;
        vocab_addr_t addr;
        char_t       ch;
    } vocab_wr_t;

    // host write port into the input word store
    typedef struct packed {
        logic        en;
        input_addr_t addr;
        char_t       ch;
    } input_wr_t;

endpackage
